//--- logic/spmv_settings.svh
`ifndef SPMV_SETTINGS_SVH
`define SPMV_SETTINGS_SVH

// value and weight width
`define SPMV_DATA_W 8

// matrix columns, also the longest row a block can carry
`define SPMV_NUM_COLS 5

// rows per block
`define SPMV_NUM_ROWS 5

// depth of the column index and value arrays in one block
`define SPMV_NNZ_SIZE 8

// column index width
`define SPMV_COL_W 3

// start offset into the nonzero arrays
`define SPMV_OFS_W 3

// row length field
`define SPMV_LEN_W 3

// row sum width, two data widths plus room for the column count
`define SPMV_SUM_W 19

`endif

//--- logic/spmv_pkg.sv
`include "spmv_settings.svh"

package spmv_pkg;

  // one row of the incoming block
  typedef struct packed {
    logic [`SPMV_OFS_W-1:0] offset;
    logic [`SPMV_LEN_W-1:0] row_len;
    logic                   flag;
  } node_info_t;

  // per-row descriptor handed from loader to MAC
  typedef struct packed {
    logic [`SPMV_LEN_W-1:0] row_len;
    logic                   flag;
  } row_info_t;

  // weight write strobe from outside
  typedef struct packed {
    logic                    en;
    logic [`SPMV_COL_W-1:0]  addr;
    logic [`SPMV_DATA_W-1:0] data;
  } weight_wr_t;

  // one row's output
  // sum is zero whenever present is clear
  typedef struct packed {
    logic                   present;
    logic [`SPMV_SUM_W-1:0] sum;
  } row_result_t;

endpackage

//--- logic/block_loader.sv
`include "spmv_settings.svh"

module block_loader (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    sched_valid_i,
  input  logic [`SPMV_COL_W-1:0]  col_idx_i     [`SPMV_NNZ_SIZE],
  input  logic [`SPMV_DATA_W-1:0] value_i       [`SPMV_NNZ_SIZE],
  input  spmv_pkg::node_info_t    node_info_i   [`SPMV_NUM_ROWS],

  output logic                    sched_ready_o,
  output logic [`SPMV_COL_W-1:0]  row_col_idx_o [`SPMV_NUM_ROWS][`SPMV_NUM_COLS],
  output logic [`SPMV_DATA_W-1:0] row_value_o   [`SPMV_NUM_ROWS][`SPMV_NUM_COLS],
  output spmv_pkg::row_info_t     row_info_o    [`SPMV_NUM_ROWS]
);

  // one bit wider than the offset so offset plus slot cannot wrap
  localparam int POS_W = `SPMV_OFS_W + 1;

  // unpacked rows before the output registers
  logic [`SPMV_COL_W-1:0]  col_d [`SPMV_NUM_ROWS][`SPMV_NUM_COLS];
  logic [`SPMV_DATA_W-1:0] val_d [`SPMV_NUM_ROWS][`SPMV_NUM_COLS];

  for (genvar r = 0; r < `SPMV_NUM_ROWS; r++) begin : g_row
    for (genvar c = 0; c < `SPMV_NUM_COLS; c++) begin : g_slot
      localparam logic [POS_W-1:0] SLOT = POS_W'(c);

      logic [POS_W-1:0] pos;
      logic             in_len;
      logic             in_array;
      logic             hit;

      // absolute position of this slot in the nonzero arrays
      assign pos = POS_W'(node_info_i[r].offset) + SLOT;

      // slot lies within the row length
      assign in_len = SLOT < POS_W'(node_info_i[r].row_len);

      // row may run off the end of the block
      assign in_array = pos < POS_W'(`SPMV_NNZ_SIZE);

      assign hit = in_len && in_array;

      // zero padding past the row or past the array
      assign col_d[r][c] = hit ? col_idx_i[pos[`SPMV_OFS_W-1:0]] : '0;
      assign val_d[r][c] = hit ? value_i[pos[`SPMV_OFS_W-1:0]] : '0;
    end
  end

  // row lists follow the inputs every clock, strobe or not
  always_ff @(posedge clk) begin
    row_col_idx_o <= col_d;
    row_value_o   <= val_d;
    for (int r = 0; r < `SPMV_NUM_ROWS; r++) begin
      row_info_o[r].row_len <= node_info_i[r].row_len;
      row_info_o[r].flag    <= node_info_i[r].flag;
    end
  end

  // ready echoes the strobe one cycle later
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sched_ready_o <= 1'b0;
    end else begin
      sched_ready_o <= sched_valid_i;
    end
  end

endmodule

//--- logic/weight_bank.sv
`include "spmv_settings.svh"

module weight_bank (
  input  logic                    clk,
  input  logic                    rst_n,

  input  spmv_pkg::weight_wr_t    weight_wr_i,

  output logic [`SPMV_DATA_W-1:0] weights_o [`SPMV_NUM_COLS]
);

  localparam int COL_W = `SPMV_COL_W;

  // one register per column
  // an address at or above the column count matches no entry and is dropped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int c = 0; c < `SPMV_NUM_COLS; c++) begin
        weights_o[c] <= '0;
      end
    end else if (weight_wr_i.en) begin
      for (int c = 0; c < `SPMV_NUM_COLS; c++) begin
        if (weight_wr_i.addr == COL_W'(c)) begin
          weights_o[c] <= weight_wr_i.data;
        end
      end
    end
  end

endmodule

//--- logic/row_mac.sv
`include "spmv_settings.svh"

module row_mac (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    start_i,
  input  logic [`SPMV_COL_W-1:0]  row_col_idx_i [`SPMV_NUM_ROWS][`SPMV_NUM_COLS],
  input  logic [`SPMV_DATA_W-1:0] row_value_i   [`SPMV_NUM_ROWS][`SPMV_NUM_COLS],
  input  spmv_pkg::row_info_t     row_info_i    [`SPMV_NUM_ROWS],
  input  logic [`SPMV_DATA_W-1:0] weights_i     [`SPMV_NUM_COLS],

  output spmv_pkg::row_result_t   result_o      [`SPMV_NUM_ROWS],
  output logic                    result_valid_o
);

  localparam int COL_W  = `SPMV_COL_W;
  localparam int PROD_W = 2 * `SPMV_DATA_W;
  localparam int PAD_W  = `SPMV_SUM_W - PROD_W;
  // leaves of the adder tree, rounded up to a power of two
  localparam int TREE_N = 2 ** $clog2(`SPMV_NUM_COLS);

  logic [`SPMV_SUM_W-1:0] row_sum [`SPMV_NUM_ROWS];

  for (genvar r = 0; r < `SPMV_NUM_ROWS; r++) begin : g_row
    always_comb begin
      logic [`SPMV_DATA_W-1:0] w;
      logic [PROD_W-1:0]       prod;
      logic [`SPMV_SUM_W-1:0]  node [2*TREE_N-1];

      // leaves: gather the column weight, multiply
      for (int c = 0; c < `SPMV_NUM_COLS; c++) begin
        w = '0;
        for (int k = 0; k < `SPMV_NUM_COLS; k++) begin
          if (row_col_idx_i[r][c] == COL_W'(k)) begin
            w = weights_i[k];
          end
        end
        prod = row_value_i[r][c] * w;
        node[TREE_N-1+c] = {{PAD_W{1'b0}}, prod};
      end

      // unused leaves
      for (int c = `SPMV_NUM_COLS; c < TREE_N; c++) begin
        node[TREE_N-1+c] = '0;
      end

      // pairwise reduction, node i sums its two children
      for (int i = TREE_N - 2; i >= 0; i--) begin
        node[i] = node[2*i+1] + node[2*i+2];
      end

      row_sum[r] = node[0];
    end
  end

  // results, sum cleared for absent rows
  always_ff @(posedge clk) begin
    for (int r = 0; r < `SPMV_NUM_ROWS; r++) begin
      result_o[r].present <= row_info_i[r].flag;
      result_o[r].sum     <= row_info_i[r].flag ? row_sum[r] : '0;
    end
  end

  // valid trails start by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= start_i;
    end
  end

endmodule

//--- logic/spmv_top.sv
`include "spmv_settings.svh"

module spmv_top (
  input  logic                    clk,
  input  logic                    rst_n,

  // block from the scheduler
  input  logic                    sched_valid_i,
  input  logic [`SPMV_COL_W-1:0]  col_idx_i   [`SPMV_NNZ_SIZE],
  input  logic [`SPMV_DATA_W-1:0] value_i     [`SPMV_NNZ_SIZE],
  input  spmv_pkg::node_info_t    node_info_i [`SPMV_NUM_ROWS],

  // weight writes
  input  spmv_pkg::weight_wr_t    weight_wr_i,

  output logic                    sched_ready_o,
  output spmv_pkg::row_result_t   result_o    [`SPMV_NUM_ROWS],
  output logic                    result_valid_o
);

  // loader to MAC
  logic [`SPMV_COL_W-1:0]  row_col_idx [`SPMV_NUM_ROWS][`SPMV_NUM_COLS];
  logic [`SPMV_DATA_W-1:0] row_value   [`SPMV_NUM_ROWS][`SPMV_NUM_COLS];
  spmv_pkg::row_info_t     row_info    [`SPMV_NUM_ROWS];

  // weight bank to MAC
  logic [`SPMV_DATA_W-1:0] weights     [`SPMV_NUM_COLS];

  block_loader u_block_loader (
    .clk           (clk),
    .rst_n         (rst_n),
    .sched_valid_i (sched_valid_i),
    .col_idx_i     (col_idx_i),
    .value_i       (value_i),
    .node_info_i   (node_info_i),
    .sched_ready_o (sched_ready_o),
    .row_col_idx_o (row_col_idx),
    .row_value_o   (row_value),
    .row_info_o    (row_info)
  );

  weight_bank u_weight_bank (
    .clk         (clk),
    .rst_n       (rst_n),
    .weight_wr_i (weight_wr_i),
    .weights_o   (weights)
  );

  // ready doubles as the MAC start, so results land two cycles after the strobe
  row_mac u_row_mac (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (sched_ready_o),
    .row_col_idx_i  (row_col_idx),
    .row_value_i    (row_value),
    .row_info_i     (row_info),
    .weights_i      (weights),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

endmodule

//--- dv/spmv_tb.sv
`include "spmv_settings.svh"

module spmv_tb;

  localparam int TIMEOUT_CYCLES = 400;
  localparam logic [31:0] RAND_SEED = 32'h8c585ecd;
  localparam int OFS_MAX = (1 << `SPMV_OFS_W) - 1;

  logic clk = 1'b0;
  logic rst_n;

  logic                    sched_valid;
  logic [`SPMV_COL_W-1:0]  col_idx   [`SPMV_NNZ_SIZE];
  logic [`SPMV_DATA_W-1:0] value     [`SPMV_NNZ_SIZE];
  spmv_pkg::node_info_t    node_info [`SPMV_NUM_ROWS];
  spmv_pkg::weight_wr_t    weight_wr;
  logic                    sched_ready;
  spmv_pkg::row_result_t   result    [`SPMV_NUM_ROWS];
  logic                    result_valid;

  // block being prepared, copied onto the inputs at the strobe
  logic [`SPMV_COL_W-1:0]  blk_col  [`SPMV_NNZ_SIZE];
  logic [`SPMV_DATA_W-1:0] blk_val  [`SPMV_NNZ_SIZE];
  spmv_pkg::node_info_t    blk_node [`SPMV_NUM_ROWS];

  // shadow of the weight bank
  logic [`SPMV_DATA_W-1:0] shadow_w [`SPMV_NUM_COLS];

  // expected results, up to three blocks in flight
  logic                    exp_present [3][`SPMV_NUM_ROWS];
  logic [`SPMV_SUM_W-1:0]  exp_sum     [3][`SPMV_NUM_ROWS];

  int    errors = 0;
  int    errors_at_start = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;
  int    cycle_count = 0;
  string test_name;

  spmv_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .sched_valid_i  (sched_valid),
    .col_idx_i      (col_idx),
    .value_i        (value),
    .node_info_i    (node_info),
    .weight_wr_i    (weight_wr),
    .sched_ready_o  (sched_ready),
    .result_o       (result),
    .result_valid_o (result_valid)
  );

  always #20 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic spmv_pkg::node_info_t make_node(input int ofs, input int len,
                                                     input logic flag);
    spmv_pkg::node_info_t n;
    n.offset  = `SPMV_OFS_W'(ofs);
    n.row_len = `SPMV_LEN_W'(len);
    n.flag    = flag;
    return n;
  endfunction

  function automatic spmv_pkg::weight_wr_t weight_cmd(input int col,
                                                      input logic [`SPMV_DATA_W-1:0] data);
    spmv_pkg::weight_wr_t wr;
    wr.en   = 1'b1;
    wr.addr = `SPMV_COL_W'(col);
    wr.data = data;
    return wr;
  endfunction

  // row sum straight from the loader and MAC rules
  function automatic logic [`SPMV_SUM_W-1:0] model_row_sum(input int r);
    logic [`SPMV_SUM_W-1:0] acc;
    int pos;
    int len;
    int col;
    acc = '0;
    len = int'(blk_node[r].row_len);
    for (int c = 0; c < `SPMV_NUM_COLS; c++) begin
      pos = int'(blk_node[r].offset) + c;
      if (c < len && pos < `SPMV_NNZ_SIZE) begin
        col = int'(blk_col[pos]);
        // no weight exists past the last column
        if (col < `SPMV_NUM_COLS) begin
          acc = acc + `SPMV_SUM_W'(blk_val[pos]) * `SPMV_SUM_W'(shadow_w[col]);
        end
      end
    end
    if (!blk_node[r].flag) begin
      acc = '0;
    end
    return acc;
  endfunction

  task automatic capture_expected(input int slot);
    for (int r = 0; r < `SPMV_NUM_ROWS; r++) begin
      exp_present[slot][r] = blk_node[r].flag;
      exp_sum[slot][r]     = model_row_sum(r);
    end
  endtask

  // rows kept inside the nonzero array, lengths up to the slot count
  task automatic random_block();
    int len;
    int ofs_max;
    for (int i = 0; i < `SPMV_NNZ_SIZE; i++) begin
      blk_col[i] = `SPMV_COL_W'($urandom % `SPMV_NUM_COLS);
      blk_val[i] = `SPMV_DATA_W'($urandom);
    end
    for (int r = 0; r < `SPMV_NUM_ROWS; r++) begin
      len = int'($urandom % (`SPMV_NUM_COLS + 1));
      ofs_max = `SPMV_NNZ_SIZE - len;
      if (ofs_max > OFS_MAX) begin
        ofs_max = OFS_MAX;
      end
      blk_node[r] = make_node(int'($urandom % (ofs_max + 1)), len, ($urandom % 4) != 0);
    end
  endtask

  task automatic write_weight(input int col, input logic [`SPMV_DATA_W-1:0] data);
    @(posedge clk);
    weight_wr <= weight_cmd(col, data);
    shadow_w[col] = data;
    @(posedge clk);
    weight_wr <= '0;
  endtask

  // call right after a rising edge
  task automatic load_inputs();
    for (int i = 0; i < `SPMV_NNZ_SIZE; i++) begin
      col_idx[i] <= blk_col[i];
      value[i]   <= blk_val[i];
    end
    for (int r = 0; r < `SPMV_NUM_ROWS; r++) begin
      node_info[r] <= blk_node[r];
    end
    sched_valid <= 1'b1;
  endtask

  task automatic expect_strobes(input logic exp_ready, input logic exp_valid,
                                input string where);
    if (sched_ready !== exp_ready) begin
      $display("** Error at %0t: %s, %s, sched_ready_o is %b, expected %b",
               $time, test_name, where, sched_ready, exp_ready);
      errors++;
    end
    if (result_valid !== exp_valid) begin
      $display("** Error at %0t: %s, %s, result_valid_o is %b, expected %b",
               $time, test_name, where, result_valid, exp_valid);
      errors++;
    end
  endtask

  task automatic compare_results(input int slot);
    for (int r = 0; r < `SPMV_NUM_ROWS; r++) begin
      if (result[r].present !== exp_present[slot][r]) begin
        $display("** Error at %0t: %s, row %0d present is %b, expected %b",
                 $time, test_name, r, result[r].present, exp_present[slot][r]);
        errors++;
      end
      if (result[r].sum !== exp_sum[slot][r]) begin
        $display("** Error at %0t: %s, row %0d sum is %0d, expected %0d",
                 $time, test_name, r, result[r].sum, exp_sum[slot][r]);
        errors++;
      end
    end
  endtask

  // strobe already loaded, drop it and check at the fixed latency
  task automatic complete_block();
    @(posedge clk);
    sched_valid <= 1'b0;
    @(negedge clk);
    expect_strobes(1'b1, 1'b0, "one cycle after strobe");
    @(negedge clk);
    expect_strobes(1'b0, 1'b1, "two cycles after strobe");
    compare_results(0);
  endtask

  task automatic send_block();
    @(posedge clk);
    load_inputs();
    complete_block();
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic reset_and_strobe_test();
    start_test("reset_and_strobe");
    repeat (4) begin
      @(negedge clk);
      expect_strobes(1'b0, 1'b0, "idle after reset");
    end
    random_block();
    capture_expected(0);
    send_block();
    @(negedge clk);
    expect_strobes(1'b0, 1'b0, "three cycles after strobe");
    end_test();
  endtask

  task automatic single_row_test();
    start_test("single_row");
    write_weight(0, 8'd3);
    write_weight(1, 8'd5);
    write_weight(2, 8'd7);
    write_weight(3, 8'd11);
    write_weight(4, 8'd13);
    blk_col = '{3'd4, 3'd0, 3'd2, 3'd1, 3'd3, 3'd0, 3'd1, 3'd2};
    blk_val = '{8'd10, 8'd20, 8'd30, 8'd40, 8'd50, 8'd60, 8'd70, 8'd80};
    blk_node[0] = make_node(2, 3, 1'b1);
    blk_node[1] = make_node(0, 2, 1'b0);
    blk_node[2] = make_node(1, 4, 1'b0);
    blk_node[3] = make_node(5, 3, 1'b0);
    blk_node[4] = make_node(0, 5, 1'b0);
    // 30*7 + 40*5 + 50*11
    for (int r = 0; r < `SPMV_NUM_ROWS; r++) begin
      exp_present[0][r] = 1'b0;
      exp_sum[0][r]     = '0;
    end
    exp_present[0][0] = 1'b1;
    exp_sum[0][0]     = `SPMV_SUM_W'(960);
    send_block();
    end_test();
  endtask

  task automatic random_block_test();
    start_test("random_blocks");
    for (int c = 0; c < `SPMV_NUM_COLS; c++) begin
      write_weight(c, `SPMV_DATA_W'($urandom));
    end
    repeat (6) begin
      random_block();
      capture_expected(0);
      send_block();
    end
    end_test();
  endtask

  task automatic edge_padding_test();
    start_test("edge_padding");
    random_block();
    blk_node[0] = make_node(3, 0, 1'b1);
    // rows 1 to 4 run off the end of the nonzero array
    blk_node[1] = make_node(6, 5, 1'b1);
    blk_node[2] = make_node(7, 3, 1'b1);
    blk_node[3] = make_node(4, 5, 1'b0);
    blk_node[4] = make_node(4, 5, 1'b1);
    capture_expected(0);
    send_block();
    end_test();
  endtask

  task automatic back_to_back_test();
    start_test("back_to_back");
    random_block();
    capture_expected(0);
    @(posedge clk);
    load_inputs();
    random_block();
    capture_expected(1);
    @(posedge clk);
    load_inputs();
    random_block();
    capture_expected(2);
    @(posedge clk);
    load_inputs();
    // first result shows while the third block is on the inputs
    @(negedge clk);
    expect_strobes(1'b1, 1'b1, "first block result");
    compare_results(0);
    @(posedge clk);
    sched_valid <= 1'b0;
    @(negedge clk);
    expect_strobes(1'b1, 1'b1, "second block result");
    compare_results(1);
    @(negedge clk);
    expect_strobes(1'b0, 1'b1, "third block result");
    compare_results(2);
    @(negedge clk);
    expect_strobes(1'b0, 1'b0, "after the last result");
    end_test();
  endtask

  task automatic weight_update_test();
    start_test("weight_update");
    write_weight(2, 8'd4);
    random_block();
    blk_col[0]  = 3'd2;
    blk_val[0]  = 8'd9;
    blk_node[0] = make_node(0, 5, 1'b1);
    capture_expected(0);
    send_block();
    // new weight lands one cycle ahead of the strobe
    @(posedge clk);
    weight_wr <= weight_cmd(2, 8'd200);
    shadow_w[2] = 8'd200;
    capture_expected(0);
    @(posedge clk);
    weight_wr <= '0;
    load_inputs();
    complete_block();
    end_test();
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    rst_n       = 1'b0;
    sched_valid = 1'b0;
    weight_wr   = '0;
    for (int i = 0; i < `SPMV_NNZ_SIZE; i++) begin
      col_idx[i] = '0;
      value[i]   = '0;
    end
    for (int r = 0; r < `SPMV_NUM_ROWS; r++) begin
      node_info[r] = '0;
    end
    for (int c = 0; c < `SPMV_NUM_COLS; c++) begin
      shadow_w[c] = '0;
    end

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    reset_and_strobe_test();
    single_row_test();
    random_block_test();
    edge_padding_test();
    back_to_back_test();
    weight_update_test();

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- spmv.f
+incdir+logic
logic/spmv_pkg.sv
logic/block_loader.sv
logic/weight_bank.sv
logic/row_mac.sv
logic/spmv_top.sv
dv/spmv_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module spmv_tb -f spmv.f -Mdir obj_dir \
  && ./obj_dir/Vspmv_tb > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$LOG"

grep -q "^Simulation finished: PASS$" "$LOG" \
  && echo "result: pass" \
  || { echo "result: fail, see $LOG"; exit 1; }
